//--- logic/ip_tx_pkg.sv
// field types, header and stream structs, framer states
// IPv4 constants and ones-complement addition
package ip_tx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ether_type_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [15:0] csum_t;
    typedef logic [4:0]  hdr_idx_t;

    localparam logic [3:0] IP_VERSION   = 4'd4;
    localparam logic [3:0] IP_IHL       = 4'd5;
    localparam int         IP_HDR_BYTES = 20;

    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        ether_type_t eth_type;
    } eth_hdr_t;

    // per-frame IPv4 fields, version and IHL are fixed
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        ip_len_t     length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        byte_t       ttl;
        byte_t       protocol;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
    } ip_hdr_t;

    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } axis_beat_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_HEADER,
        ST_WRITE_PAYLOAD,
        ST_WRITE_PAYLOAD_LAST
    } tx_state_t;

    // 16-bit add with end-around carry
    function automatic csum_t ones_add(input csum_t a, input csum_t b);
        logic [16:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[15:0] + csum_t'(sum[16]);
    endfunction

endpackage

//--- logic/ip_hdr_serializer.sv
// IPv4 header checksum register and header byte selection
`timescale 1ns/1ps

module ip_hdr_serializer
    import ip_tx_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  ip_hdr_t  ip_hdr,
    input  logic     hdr_capture,
    input  hdr_idx_t hdr_idx,
    output byte_t    hdr_byte
);

    csum_t hdr_sum;
    csum_t csum;

    // sum of the ten header words, checksum word counted as zero
    always_comb begin
        hdr_sum = {IP_VERSION, IP_IHL, ip_hdr.dscp, ip_hdr.ecn};
        hdr_sum = ones_add(hdr_sum, ip_hdr.length);
        hdr_sum = ones_add(hdr_sum, ip_hdr.identification);
        hdr_sum = ones_add(hdr_sum, {ip_hdr.flags, ip_hdr.frag_offset});
        hdr_sum = ones_add(hdr_sum, {ip_hdr.ttl, ip_hdr.protocol});
        hdr_sum = ones_add(hdr_sum, ip_hdr.src_ip[31:16]);
        hdr_sum = ones_add(hdr_sum, ip_hdr.src_ip[15:0]);
        hdr_sum = ones_add(hdr_sum, ip_hdr.dst_ip[31:16]);
        hdr_sum = ones_add(hdr_sum, ip_hdr.dst_ip[15:0]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csum <= '0;
        end else if (hdr_capture) begin
            csum <= ~hdr_sum;
        end
    end

    // network byte order
    always_comb begin
        case (hdr_idx)
            5'd0:    hdr_byte = {IP_VERSION, IP_IHL};
            5'd1:    hdr_byte = {ip_hdr.dscp, ip_hdr.ecn};
            5'd2:    hdr_byte = ip_hdr.length[15:8];
            5'd3:    hdr_byte = ip_hdr.length[7:0];
            5'd4:    hdr_byte = ip_hdr.identification[15:8];
            5'd5:    hdr_byte = ip_hdr.identification[7:0];
            5'd6:    hdr_byte = {ip_hdr.flags, ip_hdr.frag_offset[12:8]};
            5'd7:    hdr_byte = ip_hdr.frag_offset[7:0];
            5'd8:    hdr_byte = ip_hdr.ttl;
            5'd9:    hdr_byte = ip_hdr.protocol;
            5'd10:   hdr_byte = csum[15:8];
            5'd11:   hdr_byte = csum[7:0];
            5'd12:   hdr_byte = ip_hdr.src_ip[31:24];
            5'd13:   hdr_byte = ip_hdr.src_ip[23:16];
            5'd14:   hdr_byte = ip_hdr.src_ip[15:8];
            5'd15:   hdr_byte = ip_hdr.src_ip[7:0];
            5'd16:   hdr_byte = ip_hdr.dst_ip[31:24];
            5'd17:   hdr_byte = ip_hdr.dst_ip[23:16];
            5'd18:   hdr_byte = ip_hdr.dst_ip[15:8];
            5'd19:   hdr_byte = ip_hdr.dst_ip[7:0];
            default: hdr_byte = '0;
        endcase
    end

    a_hdr_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        hdr_idx < hdr_idx_t'(IP_HDR_BYTES)
    ) else $error("header index out of range");

endmodule

//--- logic/ip_tx_framer.sv
// IPv4 transmit FSM with header capture and payload length check
`timescale 1ns/1ps

module ip_tx_framer
    import ip_tx_pkg::*;
#(
    parameter int HDR_BYTES = 20
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       s_ip_hdr_valid,
    output logic       s_ip_hdr_ready,
    input  eth_hdr_t   s_eth_hdr,
    input  ip_hdr_t    s_ip_hdr,
    input  axis_beat_t s_payload,
    input  logic       s_payload_valid,
    output logic       s_payload_ready,
    output eth_hdr_t   m_eth_hdr,
    output logic       m_eth_hdr_valid,
    input  logic       m_eth_hdr_ready,
    output ip_hdr_t    ip_hdr,
    output logic       hdr_capture,
    output hdr_idx_t   hdr_idx,
    input  byte_t      hdr_byte,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       in_ready,
    input  logic       in_ready_early,
    output logic       error_payload_early_termination
);

    tx_state_t state;
    tx_state_t state_next;
    hdr_idx_t  hdr_idx_next;
    ip_len_t   word_count;
    ip_len_t   word_count_next;
    byte_t     held_byte;
    logic      store_held;
    logic      accept;
    logic      hdr_ready_next;
    logic      payload_ready_next;
    logic      eth_valid_next;
    logic      error_next;
    logic      payload_xfer;

    assign payload_xfer = s_payload_ready && s_payload_valid;

    always_comb begin
        state_next         = state;
        hdr_idx_next       = hdr_idx;
        word_count_next    = word_count;
        store_held         = 1'b0;
        accept             = 1'b0;
        hdr_ready_next     = 1'b0;
        payload_ready_next = 1'b0;
        eth_valid_next     = m_eth_hdr_valid && !m_eth_hdr_ready;
        error_next         = 1'b0;
        out_beat           = '0;
        out_valid          = 1'b0;

        case (state)
            ST_IDLE: begin
                hdr_idx_next   = '0;
                hdr_ready_next = !eth_valid_next;
                if (s_ip_hdr_ready && s_ip_hdr_valid) begin
                    accept          = 1'b1;
                    hdr_ready_next  = 1'b0;
                    eth_valid_next  = 1'b1;
                    word_count_next = s_ip_hdr.length - ip_len_t'(HDR_BYTES);
                    state_next      = ST_WRITE_HEADER;
                end
            end
            ST_WRITE_HEADER: begin
                out_beat.data = hdr_byte;
                if (in_ready) begin
                    out_valid    = 1'b1;
                    hdr_idx_next = hdr_idx + 1'b1;
                    if (hdr_idx == hdr_idx_t'(HDR_BYTES - 1)) begin
                        hdr_idx_next       = '0;
                        payload_ready_next = in_ready_early;
                        state_next         = ST_WRITE_PAYLOAD;
                    end
                end
            end
            ST_WRITE_PAYLOAD: begin
                payload_ready_next = in_ready_early;
                out_beat           = s_payload;
                if (payload_xfer) begin
                    word_count_next = word_count - 1'b1;
                    out_valid       = 1'b1;
                    if (s_payload.last) begin
                        // short frame, flag the final byte
                        if (word_count != ip_len_t'(1)) begin
                            out_beat.user = 1'b1;
                            error_next    = 1'b1;
                        end
                        hdr_ready_next     = !eth_valid_next;
                        payload_ready_next = 1'b0;
                        state_next         = ST_IDLE;
                    end else if (word_count == ip_len_t'(1)) begin
                        // declared length reached, hold byte until input last
                        store_held = 1'b1;
                        out_valid  = 1'b0;
                        state_next = ST_WRITE_PAYLOAD_LAST;
                    end
                end
            end
            ST_WRITE_PAYLOAD_LAST: begin
                payload_ready_next = in_ready_early;
                out_beat.data      = held_byte;
                out_beat.last      = 1'b1;
                out_beat.user      = s_payload.user;
                if (payload_xfer && s_payload.last) begin
                    out_valid          = 1'b1;
                    hdr_ready_next     = !eth_valid_next;
                    payload_ready_next = 1'b0;
                    state_next         = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state                           <= ST_IDLE;
            hdr_idx                         <= '0;
            word_count                      <= '0;
            s_ip_hdr_ready                  <= 1'b0;
            s_payload_ready                 <= 1'b0;
            m_eth_hdr_valid                 <= 1'b0;
            hdr_capture                     <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state                           <= state_next;
            hdr_idx                         <= hdr_idx_next;
            word_count                      <= word_count_next;
            s_ip_hdr_ready                  <= hdr_ready_next;
            s_payload_ready                 <= payload_ready_next;
            m_eth_hdr_valid                 <= eth_valid_next;
            hdr_capture                     <= accept;
            error_payload_early_termination <= error_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m_eth_hdr <= s_eth_hdr;
            ip_hdr    <= s_ip_hdr;
        end
        if (store_held) begin
            held_byte <= s_payload.data;
        end
    end

    // skid buffer only has room when its registered ready is high
    a_offer_when_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> in_ready
    ) else $error("beat offered while skid buffer not ready");

    a_hdr_idx_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        hdr_idx < hdr_idx_t'(HDR_BYTES)
    ) else $error("header index past header length");

endmodule

//--- logic/axis_skid_buffer.sv
// two-slot registered output stage for the byte stream
`timescale 1ns/1ps

module axis_skid_buffer
    import ip_tx_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output logic       in_ready_early,
    output axis_beat_t m_payload,
    output logic       m_payload_valid,
    input  logic       m_payload_ready
);

    axis_beat_t temp_beat;
    logic       temp_valid;
    logic       out_valid_next;
    logic       temp_valid_next;
    logic       store_in_to_out;
    logic       store_in_to_temp;
    logic       store_temp_to_out;

    // ready next cycle if the sink takes a beat or both slots are empty
    assign in_ready_early = m_payload_ready || (!temp_valid && !m_payload_valid);

    always_comb begin
        out_valid_next    = m_payload_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready) begin
            if (m_payload_ready || !m_payload_valid) begin
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // sink stalled, park the beat
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_payload_ready) begin
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ready        <= 1'b0;
            m_payload_valid <= 1'b0;
            temp_valid      <= 1'b0;
        end else begin
            in_ready        <= in_ready_early;
            m_payload_valid <= out_valid_next;
            temp_valid      <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_payload <= in_beat;
        end else if (store_temp_to_out) begin
            m_payload <= temp_beat;
        end
        if (store_in_to_temp) begin
            temp_beat <= in_beat;
        end
    end

    a_stall_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        m_payload_valid && !m_payload_ready |=> m_payload_valid && $stable(m_payload)
    ) else $error("output beat changed during stall");

endmodule

//--- logic/ip_eth_tx.sv
// IPv4 transmit top level
// framer, header serializer and output skid buffer
`timescale 1ns/1ps

module ip_eth_tx
    import ip_tx_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       s_ip_hdr_valid,
    output logic       s_ip_hdr_ready,
    input  eth_hdr_t   s_eth_hdr,
    input  ip_hdr_t    s_ip_hdr,
    input  axis_beat_t s_payload,
    input  logic       s_payload_valid,
    output logic       s_payload_ready,
    output eth_hdr_t   m_eth_hdr,
    output logic       m_eth_hdr_valid,
    input  logic       m_eth_hdr_ready,
    output axis_beat_t m_payload,
    output logic       m_payload_valid,
    input  logic       m_payload_ready,
    output logic       error_payload_early_termination
);

    ip_hdr_t    ip_hdr;
    logic       hdr_capture;
    hdr_idx_t   hdr_idx;
    byte_t      hdr_byte;
    axis_beat_t out_beat;
    logic       out_valid;
    logic       in_ready;
    logic       in_ready_early;

    ip_tx_framer #(
        .HDR_BYTES (IP_HDR_BYTES)
    ) i_framer (
        .clk                             (clk),
        .rst_n                           (rst_n),
        .s_ip_hdr_valid                  (s_ip_hdr_valid),
        .s_ip_hdr_ready                  (s_ip_hdr_ready),
        .s_eth_hdr                       (s_eth_hdr),
        .s_ip_hdr                        (s_ip_hdr),
        .s_payload                       (s_payload),
        .s_payload_valid                 (s_payload_valid),
        .s_payload_ready                 (s_payload_ready),
        .m_eth_hdr                       (m_eth_hdr),
        .m_eth_hdr_valid                 (m_eth_hdr_valid),
        .m_eth_hdr_ready                 (m_eth_hdr_ready),
        .ip_hdr                          (ip_hdr),
        .hdr_capture                     (hdr_capture),
        .hdr_idx                         (hdr_idx),
        .hdr_byte                        (hdr_byte),
        .out_beat                        (out_beat),
        .out_valid                       (out_valid),
        .in_ready                        (in_ready),
        .in_ready_early                  (in_ready_early),
        .error_payload_early_termination (error_payload_early_termination)
    );

    ip_hdr_serializer i_serializer (
        .clk         (clk),
        .rst_n       (rst_n),
        .ip_hdr      (ip_hdr),
        .hdr_capture (hdr_capture),
        .hdr_idx     (hdr_idx),
        .hdr_byte    (hdr_byte)
    );

    axis_skid_buffer i_skid (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_beat         (out_beat),
        .in_valid        (out_valid),
        .in_ready        (in_ready),
        .in_ready_early  (in_ready_early),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready)
    );

endmodule

//--- testbench/ip_eth_tx_checker.sv
// output monitor for the IPv4 transmit framer
// builds expected frames and compares header and byte stream
`timescale 1ns/1ps

module ip_eth_tx_checker
    import ip_tx_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  eth_hdr_t   m_eth_hdr,
    input  logic       m_eth_hdr_valid,
    input  logic       m_eth_hdr_ready,
    input  axis_beat_t m_payload,
    input  logic       m_payload_valid,
    input  logic       m_payload_ready,
    input  logic       error_payload_early_termination
);

    axis_beat_t exp_beats[$];
    eth_hdr_t   exp_eth[$];
    bit         exp_err[$];
    int         cur_n;
    int         cur_declared;
    logic [15:0] cur_csum;
    int         num_frames = 0;
    int         frames_done = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         data_errors = 0;
    int         eth_seen = 0;
    int         err_seen = 0;
    int         byte_pos = 0;
    bit         frame_bad = 0;

    // 16-bit sum with the carry folded back in
    function automatic logic [15:0] end_around_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + {15'd0, s[16]};
    endfunction

    task automatic push_byte(input logic [7:0] d, input logic l, input logic u);
        axis_beat_t b;
        b.data = d;
        b.last = l;
        b.user = u;
        exp_beats.push_back(b);
    endtask

    // 20 header bytes, big-endian
    task automatic add_frame_start(input eth_hdr_t eth, input ip_hdr_t ip, input int n);
        logic [7:0]  hb[20];
        logic [15:0] sum;
        hb[0]  = 8'h45;
        hb[1]  = {ip.dscp, ip.ecn};
        hb[2]  = ip.length[15:8];
        hb[3]  = ip.length[7:0];
        hb[4]  = ip.identification[15:8];
        hb[5]  = ip.identification[7:0];
        hb[6]  = {ip.flags, ip.frag_offset[12:8]};
        hb[7]  = ip.frag_offset[7:0];
        hb[8]  = ip.ttl;
        hb[9]  = ip.protocol;
        hb[10] = 8'h00;
        hb[11] = 8'h00;
        for (int i = 0; i < 4; i++) begin
            hb[12 + i] = ip.src_ip[31 - 8 * i -: 8];
            hb[16 + i] = ip.dst_ip[31 - 8 * i -: 8];
        end
        sum = 16'h0000;
        for (int i = 0; i < 10; i++) begin
            sum = end_around_add(sum, {hb[2 * i], hb[2 * i + 1]});
        end
        cur_csum = ~sum;
        hb[10] = cur_csum[15:8];
        hb[11] = cur_csum[7:0];
        for (int i = 0; i < 20; i++) begin
            push_byte(hb[i], 1'b0, 1'b0);
        end
        cur_n = n;
        cur_declared = int'(ip.length) - 20;
        exp_eth.push_back(eth);
        exp_err.push_back(n < cur_declared);
        num_frames++;
    endtask

    // bytes past the declared length are dropped
    task automatic add_byte(input logic [7:0] d, input int i);
        if (i < cur_declared) begin
            push_byte(d, (i == cur_n - 1) || (i == cur_declared - 1),
                      (i == cur_n - 1) && (cur_n < cur_declared));
        end
    endtask

    task automatic add_frame_end(input logic [15:0] f_csum, input int f_len, input bit f_err);
        int len;
        len = (cur_n < cur_declared) ? cur_n : cur_declared;
        if (f_csum !== cur_csum || f_len != len || f_err != (cur_n < cur_declared)) begin
            $display("Error at %0t: frame %0d testdata checksum/length/error disagree",
                     $time, num_frames - 1);
            data_errors++;
        end
    endtask

    task automatic report_beat_mismatch(input axis_beat_t got, input axis_beat_t exp_beat);
        $display("Error at %0t: frame %0d byte %0d data/last/user got %h/%b/%b expected %h/%b/%b",
                 $time, frames_done, byte_pos, got.data, got.last, got.user,
                 exp_beat.data, exp_beat.last, exp_beat.user);
    endtask

    always @(posedge clk) begin
        axis_beat_t e;
        if (rst_n) begin
            if (error_payload_early_termination) begin
                err_seen++;
            end
            if (m_eth_hdr_valid && m_eth_hdr_ready) begin
                if (eth_seen >= exp_eth.size()) begin
                    $display("extra Ethernet header transfer at %0t", $time);
                    fail_count++;
                end else if (m_eth_hdr !== exp_eth[eth_seen]) begin
                    $display("Error at %0t: frame %0d m_eth_hdr got %h expected %h",
                             $time, eth_seen, m_eth_hdr, exp_eth[eth_seen]);
                    frame_bad = 1;
                end
                eth_seen++;
            end
            if (m_payload_valid && m_payload_ready) begin
                if (exp_beats.size() == 0) begin
                    $display("unexpected output byte %h at %0t", m_payload.data, $time);
                    frame_bad = 1;
                end else begin
                    e = exp_beats.pop_front();
                    if (m_payload !== e) begin
                        report_beat_mismatch(m_payload, e);
                        frame_bad = 1;
                    end
                end
                byte_pos++;
                if (m_payload.last) begin
                    if (frames_done < num_frames && err_seen != int'(exp_err[frames_done])) begin
                        $display("Error at %0t: frame %0d error pulses got %0d expected %0d",
                                 $time, frames_done, err_seen, exp_err[frames_done]);
                        frame_bad = 1;
                    end
                    if (frame_bad) begin
                        $display("frame %0d: mismatch", frames_done);
                        fail_count++;
                    end else begin
                        $display("frame %0d: ok, %0d bytes", frames_done, byte_pos);
                        pass_count++;
                    end
                    frames_done++;
                    err_seen = 0;
                    byte_pos = 0;
                    frame_bad = 0;
                end
            end
        end
    end

    task automatic finish_checks();
        if (eth_seen != num_frames) begin
            $display("Ethernet header transfers %0d do not match %0d frames",
                     eth_seen, num_frames);
            fail_count++;
        end
        if (exp_beats.size() != 0) begin
            $display("%0d expected output bytes never appeared", exp_beats.size());
            fail_count++;
        end
        if (byte_pos != 0) begin
            $display("%0d output bytes followed the final frame end", byte_pos);
            fail_count++;
        end
    endtask

endmodule

//--- testbench/tb_ip_eth_tx.sv
// testbench for the IPv4 transmit framer
// reads frames from the data file, drives headers and payload
`timescale 1ns/1ps

module tb_ip_eth_tx;
    import ip_tx_pkg::*;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       s_ip_hdr_valid = 1'b0;
    logic       s_ip_hdr_ready;
    eth_hdr_t   s_eth_hdr = '0;
    ip_hdr_t    s_ip_hdr = '0;
    axis_beat_t s_payload = '0;
    logic       s_payload_valid = 1'b0;
    logic       s_payload_ready;
    eth_hdr_t   m_eth_hdr;
    logic       m_eth_hdr_valid;
    logic       m_eth_hdr_ready = 1'b1;
    axis_beat_t m_payload;
    logic       m_payload_valid;
    logic       m_payload_ready = 1'b0;
    logic       error_payload_early_termination;

    eth_hdr_t   frame_eth[$];
    ip_hdr_t    frame_ip[$];
    int         frame_len[$];
    byte_t      pay_bytes[$];
    int         limit = 1000;
    int         cycles = 0;
    bit         timed_out = 0;
    int         seed_value;

    always #10 clk = ~clk;

    ip_eth_tx i_dut (.*);

    ip_eth_tx_checker i_checker (.*);

    // byte counts are decimal, all other fields hex
    task automatic load_frames();
        int fd;
        int rc;
        string line;
        logic [47:0] v[14];
        logic [7:0]  b;
        logic [15:0] f_csum;
        int          f_len;
        int          f_err;
        fd = $fopen("testbench/ip_eth_tx_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
        end else begin
            rc = $fgets(line, fd);
            rc = $fgets(line, fd);
            forever begin
                rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                             v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                             v[9], v[10], v[11], v[12], v[13]);
                if (rc != 14) break;
                frame_eth.push_back({v[0], v[1], v[2][15:0]});
                frame_ip.push_back({v[3][5:0], v[4][1:0], v[5][15:0], v[6][15:0], v[7][2:0],
                                    v[8][12:0], v[9][7:0], v[10][7:0], v[11][31:0], v[12][31:0]});
                frame_len.push_back(int'(v[13]));
                i_checker.add_frame_start(frame_eth[$], frame_ip[$], int'(v[13]));
                for (int i = 0; i < int'(v[13]); i++) begin
                    rc = $fscanf(fd, "%h", b);
                    pay_bytes.push_back(b);
                    i_checker.add_byte(b, i);
                end
                rc = $fscanf(fd, "%h %d %d", f_csum, f_len, f_err);
                i_checker.add_frame_end(f_csum, f_len, f_err[0]);
                limit += 4 * (20 + int'(v[13]));
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_headers();
        for (int k = 0; k < frame_eth.size(); k++) begin
            s_eth_hdr = frame_eth[k];
            s_ip_hdr = frame_ip[k];
            s_ip_hdr_valid = 1'b1;
            do @(posedge clk); while (!s_ip_hdr_ready);
            #1;
            s_ip_hdr_valid = 1'b0;
            // second frame sees a stalled Ethernet header sink
            if (k == 1) begin
                m_eth_hdr_ready = 1'b0;
                repeat (4) @(posedge clk);
                #1;
                m_eth_hdr_ready = 1'b1;
            end
        end
    endtask

    task automatic drive_payload();
        int pos;
        pos = 0;
        for (int k = 0; k < frame_len.size(); k++) begin
            for (int i = 0; i < frame_len[k]; i++) begin
                s_payload.data = pay_bytes[pos];
                s_payload.last = (i == frame_len[k] - 1);
                s_payload.user = 1'b0;
                s_payload_valid = 1'b1;
                do @(posedge clk); while (!s_payload_ready);
                #1;
                pos++;
            end
        end
        s_payload_valid = 1'b0;
    endtask

    initial begin
        seed_value = $urandom(32'h2aeef2dd);
        load_frames();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            drive_headers();
            drive_payload();
            forever begin
                // sink stalls about one cycle in four
                m_payload_ready = ($urandom % 4) != 0;
                @(posedge clk);
                #1;
            end
        join_none
        while (i_checker.frames_done < frame_eth.size() && !timed_out) begin
            @(posedge clk);
            cycles++;
            timed_out = (cycles >= limit);
        end
        repeat (5) @(posedge clk);
        if (timed_out) begin
            $display("timeout: frames not completed");
        end
        i_checker.finish_checks();
        $display("frames passed %0d failed %0d", i_checker.pass_count, i_checker.fail_count);
        if (!timed_out && frame_eth.size() != 0 &&
            i_checker.fail_count == 0 && i_checker.data_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
logic/ip_tx_pkg.sv
logic/ip_hdr_serializer.sv
logic/ip_tx_framer.sv
logic/axis_skid_buffer.sv
logic/ip_eth_tx.sv
testbench/ip_eth_tx_checker.sv
testbench/tb_ip_eth_tx.sv

//--- testbench/ip_eth_tx_testdata.txt
# dmac smac type dscp ecn length ident flags frag ttl proto src_ip dst_ip nbytes
# then nbytes payload bytes, expected checksum, output payload length, error flag
0a1b2c3d4e5f 020000000001 0800 00 0 0018 0001 2 0000 40 11 0a000001 0a000002 4
11 22 33 44
26d2 4 0
ffffffffffff 020000000002 0800 2e 0 001a 1234 0 0000 80 06 c0a80001 c0a800fe 6
a0 a1 a2 a3 a4 a5
a5a2 6 0
0a1b2c3d4e5f 020000000001 0800 00 0 0020 0002 2 0000 40 11 0a000001 0a000002 5
01 02 03 04 05
26c9 5 1
0a1b2c3d4e5f 020000000001 0800 00 0 0017 0003 2 0000 40 11 0a000001 0a000002 7
b0 b1 b2 b3 b4 b5 b6
26d1 3 0
0a1b2c3d4e5f 020000000001 0800 00 0 0015 0004 2 0000 40 11 0a000001 0a000002 1
c7
26d2 1 0
112233445566 778899aabbcc 0800 00 0 0028 beef 0 0000 ff 01 01020304 05060708 20
00 11 22 33 44 55 66 77 88 99
aa bb cc dd ee ff 5a a5 3c c3
ecd1 20 0
0a1b2c3d4e5f 020000000001 0800 00 0 0019 0005 2 0000 40 11 0a000001 0a000002 4
d0 d1 d2 d3
26cd 4 1
